// File: verilog/mldsa_defines.svh
// Scheme constants, widths and APB register map of the z-decoder
// Only ML-DSA-87 (L = 7, gamma1 = 2^19) is supported, and the decode
// arithmetic assumes exactly these values of gamma1 and q
`ifndef MLDSA_DEFINES_SVH
`define MLDSA_DEFINES_SVH

// ========================================
// Scheme constants
// ========================================
`define MLDSA_Q 8380417
`define MLDSA_N 256
`define MLDSA_L 7
`define MLDSA_GAMMA1_BITS 19
`define MLDSA_REG_SIZE 24

// Memory geometry, four coefficients per word
`define MLDSA_MEM_ADDR_WIDTH 10
`define MLDSA_SIG_ADDR_WIDTH 9
`define MLDSA_Z_WORDS ((`MLDSA_L * `MLDSA_N) / 4)

// ========================================
// APB register map
// ========================================
`define APB_CTRL_ADDR 16'h0000
`define APB_STATUS_ADDR 16'h0004
`define APB_DEST_ADDR 16'h0008
`define APB_SIG_BASE 16'h1000
`define APB_POLY_BASE 16'h4000

`endif

// File: verilog/mldsa_mem_pkg.sv
// Request types for the polynomial memory and the signature buffer
// Address widths come from the defines header
`include "mldsa_defines.svh"

package mldsa_mem_pkg;

    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } rw_cmd_e;

    // Request to the polynomial memory, 1024 words
    typedef struct packed {
        rw_cmd_e                          rd_wr_en;
        logic [`MLDSA_MEM_ADDR_WIDTH-1:0] addr;
    } mem_if_t;

    // Request to the signature buffer as the decoder issues it
    typedef struct packed {
        rw_cmd_e                          rd_wr_en;
        logic [`MLDSA_SIG_ADDR_WIDTH-1:0] addr;
    } sig_mem_if_t;

endpackage

// File: verilog/mldsa_coeff_pkg.sv
// Payload types of the z-decoder
// Lane 0 of a word is the lowest coefficient index
`include "mldsa_defines.svh"

package mldsa_coeff_pkg;

    // Encoded z value, gamma1 bits plus one
    typedef logic [`MLDSA_GAMMA1_BITS:0] enc_z_t;

    // Decoded coefficient modulo q
    typedef logic [`MLDSA_REG_SIZE-1:0] coeff_t;

    // Four lanes per memory word
    typedef enc_z_t [3:0] sig_word_t;
    typedef coeff_t [3:0] poly_word_t;

endpackage

// File: verilog/sigdecode_z_unit.sv
// One decoding lane with a single register stage
// Correct only for gamma1 = 2^19 and the ML-DSA modulus q
`timescale 1ns/1ps
`include "mldsa_defines.svh"

module sigdecode_z_unit (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  mldsa_coeff_pkg::enc_z_t data_i,
    output mldsa_coeff_pkg::coeff_t data_o
);

    localparam int W  = `MLDSA_REG_SIZE;
    localparam int W1 = W + 1;

    logic [W:0]   diff;
    logic [W-1:0] fixup;

    // The extra top bit holds the sign of gamma1 - z
    assign diff  = W1'(1 << `MLDSA_GAMMA1_BITS) - W1'(data_i);
    // A negative difference wraps into range by adding q
    assign fixup = diff[W] ? W'(`MLDSA_Q) : '0;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            data_o <= '0;
        end else if (zeroize) begin
            data_o <= '0;
        end else begin
            data_o <= diff[W-1:0] + fixup;
        end
    end

endmodule

// File: verilog/sigdecode_z_top.sv
// Signature z-decoder controller with eight decoding lanes
// Reads two buffer words per cycle and writes two polynomial words per cycle
// No back-pressure: both memories must accept every request
// Done pulses one cycle after the last write request
`timescale 1ns/1ps
`include "mldsa_defines.svh"

module sigdecode_z_top (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize,
    input  logic                                sigdecode_z_enable,
    input  logic [`MLDSA_MEM_ADDR_WIDTH-1:0]    dest_base_addr,
    output mldsa_mem_pkg::mem_if_t              mem_a_wr_req,
    output mldsa_mem_pkg::mem_if_t              mem_b_wr_req,
    output mldsa_coeff_pkg::poly_word_t         mem_a_wr_data,
    output mldsa_coeff_pkg::poly_word_t         mem_b_wr_data,
    output mldsa_mem_pkg::sig_mem_if_t          sigmem_a_rd_req,
    output mldsa_mem_pkg::sig_mem_if_t          sigmem_b_rd_req,
    input  mldsa_coeff_pkg::sig_word_t          sigmem_a_rd_data,
    input  mldsa_coeff_pkg::sig_word_t          sigmem_b_rd_data,
    output logic                                sigdecode_z_done
);

    localparam int SAW = `MLDSA_SIG_ADDR_WIDTH;
    localparam int MAW = `MLDSA_MEM_ADDR_WIDTH;
    localparam logic [SAW-1:0] LAST_WORD = SAW'(`MLDSA_Z_WORDS - 1);

    typedef enum logic [2:0] {
        IDLE,
        READ,
        READ_and_EXEC,
        READ_EXEC_and_WRITE,
        EXEC_and_WRITE,
        WRITE,
        DONE
    } state_e;

    state_e         state;
    state_e         next_state;
    logic [SAW-1:0] api_cnt;
    logic [MAW-1:0] mem_cnt;
    logic [MAW-1:0] locked_dest_addr;
    logic           rd_phase;
    logic           wr_phase;

    // Reads lead writes by two cycles, one for the buffer and one for the lanes
    assign rd_phase = state inside {READ, READ_and_EXEC, READ_EXEC_and_WRITE};
    assign wr_phase = state inside {READ_EXEC_and_WRITE, EXEC_and_WRITE, WRITE};

    // ========================================
    // State machine
    // ========================================
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:                if (sigdecode_z_enable) next_state = READ;
            READ:                next_state = READ_and_EXEC;
            READ_and_EXEC:       next_state = READ_EXEC_and_WRITE;
            READ_EXEC_and_WRITE: begin
                // Leave once the pair ending in the last word has been read
                if (api_cnt + SAW'(1) == LAST_WORD) begin
                    next_state = EXEC_and_WRITE;
                end
            end
            EXEC_and_WRITE:      next_state = WRITE;
            WRITE:               next_state = DONE;
            default:             next_state = IDLE;
        endcase
    end

    // Operand counters, the locked destination and the done pulse
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            api_cnt          <= '0;
            mem_cnt          <= '0;
            locked_dest_addr <= '0;
            sigdecode_z_done <= 1'b0;
        end else begin
            if (sigdecode_z_enable && state == IDLE) begin
                locked_dest_addr <= dest_base_addr;
            end
            api_cnt          <= rd_phase ? api_cnt + SAW'(2) : '0;
            mem_cnt          <= wr_phase ? mem_cnt + MAW'(2) : '0;
            sigdecode_z_done <= (state == DONE);
        end
    end

    // ========================================
    // Registered memory requests
    // ========================================
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize || !rd_phase) begin
            sigmem_a_rd_req <= '{rd_wr_en: mldsa_mem_pkg::RW_IDLE, addr: '0};
            sigmem_b_rd_req <= '{rd_wr_en: mldsa_mem_pkg::RW_IDLE, addr: '0};
        end else begin
            sigmem_a_rd_req <= '{rd_wr_en: mldsa_mem_pkg::RW_READ, addr: api_cnt};
            sigmem_b_rd_req <= '{rd_wr_en: mldsa_mem_pkg::RW_READ, addr: api_cnt + SAW'(1)};
        end
    end

    // Write requests line up with the lane outputs of the same word pair
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize || !wr_phase) begin
            mem_a_wr_req <= '{rd_wr_en: mldsa_mem_pkg::RW_IDLE, addr: '0};
            mem_b_wr_req <= '{rd_wr_en: mldsa_mem_pkg::RW_IDLE, addr: '0};
        end else begin
            mem_a_wr_req <= '{rd_wr_en: mldsa_mem_pkg::RW_WRITE,
                              addr: locked_dest_addr + mem_cnt};
            mem_b_wr_req <= '{rd_wr_en: mldsa_mem_pkg::RW_WRITE,
                              addr: locked_dest_addr + mem_cnt + MAW'(1)};
        end
    end

    // Four lanes per read port
    for (genvar i = 0; i < 4; i++) begin : g_lane
        sigdecode_z_unit u_dec_a (
            .clk     (clk),
            .reset_n (reset_n),
            .zeroize (zeroize),
            .data_i  (sigmem_a_rd_data[i]),
            .data_o  (mem_a_wr_data[i])
        );

        sigdecode_z_unit u_dec_b (
            .clk     (clk),
            .reset_n (reset_n),
            .zeroize (zeroize),
            .data_i  (sigmem_b_rd_data[i]),
            .data_o  (mem_b_wr_data[i])
        );
    end

endmodule

// File: verilog/mldsa_dp_mem.sv
// Two-port synchronous memory with one cycle of read latency
// Addresses must stay below DEPTH; contents are not cleared by reset
// Writes to one address from both ports in one cycle are undefined
`timescale 1ns/1ps

module mldsa_dp_mem #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 1024
) (
    input  logic                   clk,
    input  mldsa_mem_pkg::mem_if_t a_req,
    input  mldsa_mem_pkg::mem_if_t b_req,
    input  word_t                  a_wdata,
    input  word_t                  b_wdata,
    output word_t                  a_rdata,
    output word_t                  b_rdata
);

    localparam int AW = $clog2(DEPTH);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (a_req.rd_wr_en == mldsa_mem_pkg::RW_WRITE) begin
            mem[a_req.addr[AW-1:0]] <= a_wdata;
        end
        if (b_req.rd_wr_en == mldsa_mem_pkg::RW_WRITE) begin
            mem[b_req.addr[AW-1:0]] <= b_wdata;
        end
        // Read data holds until the next read on that port
        if (a_req.rd_wr_en == mldsa_mem_pkg::RW_READ) begin
            a_rdata <= mem[a_req.addr[AW-1:0]];
        end
        if (b_req.rd_wr_en == mldsa_mem_pkg::RW_READ) begin
            b_rdata <= mem[b_req.addr[AW-1:0]];
        end
    end

endmodule

// File: verilog/mldsa_apb_ctrl.sv
// APB3 slave of the z-decoder with the register map of the defines header
// Sig writes and poly reads are refused with pslverr while busy
// Poly reads take two wait states; every other access takes none
// Port a of both memories belongs to the decoder while busy
`timescale 1ns/1ps
`include "mldsa_defines.svh"

module mldsa_apb_ctrl (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [15:0]                      paddr,
    input  logic [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr,
    output logic                             sigdecode_z_enable,
    output logic                             zeroize,
    output logic [`MLDSA_MEM_ADDR_WIDTH-1:0] dest_base_addr,
    input  logic                             sigdecode_z_done,
    input  mldsa_mem_pkg::sig_mem_if_t       dec_sig_req,
    input  mldsa_mem_pkg::mem_if_t           dec_mem_req,
    input  mldsa_coeff_pkg::poly_word_t      dec_mem_wdata,
    output mldsa_mem_pkg::mem_if_t           sig_a_req,
    output mldsa_coeff_pkg::sig_word_t       sig_a_wdata,
    output mldsa_mem_pkg::mem_if_t           poly_a_req,
    output mldsa_coeff_pkg::poly_word_t      poly_a_wdata,
    input  mldsa_coeff_pkg::poly_word_t      poly_a_rdata
);

    localparam int MAW = `MLDSA_MEM_ADDR_WIDTH;

    logic                                   access;
    logic                                   in_sig;
    logic                                   in_poly;
    logic                                   poly_rd;
    logic                                   sig_wr;
    logic                                   err;
    logic [15:0]                            sig_off;
    logic [15:0]                            poly_off;
    logic [1:0]                             lane;
    logic [1:0]                             rd_phase;
    logic                                   busy;
    logic                                   done;
    mldsa_coeff_pkg::enc_z_t [2:0]          stage;
    mldsa_coeff_pkg::sig_word_t             apb_sig_wdata;
    mldsa_mem_pkg::mem_if_t                 apb_sig_req;
    mldsa_mem_pkg::mem_if_t                 apb_poly_req;
    mldsa_mem_pkg::mem_if_t                 dec_sig_wide;

    // ========================================
    // Address decode and APB response
    // ========================================
    assign access   = psel & penable;
    assign sig_off  = paddr - `APB_SIG_BASE;
    assign poly_off = paddr - `APB_POLY_BASE;
    assign in_sig   = (paddr >= `APB_SIG_BASE) && (sig_off < 16'(`MLDSA_Z_WORDS * 16));
    assign in_poly  = (paddr >= `APB_POLY_BASE) && (poly_off < 16'(1 << (MAW + 4)));
    // Both windows are word aligned, so bits 3:2 pick the lane
    assign lane     = paddr[3:2];
    assign poly_rd  = in_poly & !pwrite & !busy;
    assign sig_wr   = access & in_sig & pwrite & !busy;

    assign err = !(paddr == `APB_CTRL_ADDR || paddr == `APB_STATUS_ADDR ||
                   paddr == `APB_DEST_ADDR || in_sig || in_poly)
               || (in_sig && (!pwrite || busy))
               || (in_poly && (pwrite || busy));

    assign pready  = access & (!poly_rd | rd_phase == 2'd2);
    assign pslverr = access & err;

    always_comb begin
        prdata = '0;
        if (paddr == `APB_STATUS_ADDR) begin
            prdata = {30'b0, busy, done};
        end else if (paddr == `APB_DEST_ADDR) begin
            prdata = 32'(dest_base_addr);
        end else if (in_poly) begin
            prdata = 32'(poly_a_rdata[lane]);
        end
    end

    // Control registers and the decoder handshake
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy               <= 1'b0;
            done               <= 1'b0;
            dest_base_addr     <= '0;
            sigdecode_z_enable <= 1'b0;
            zeroize            <= 1'b0;
        end else begin
            sigdecode_z_enable <= 1'b0;
            zeroize            <= 1'b0;
            if (sigdecode_z_done && busy) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (access && pwrite && paddr == `APB_CTRL_ADDR) begin
                // Zeroize wins over a start in the same write
                if (pwdata[1]) begin
                    zeroize <= 1'b1;
                    busy    <= 1'b0;
                end else if (pwdata[0] && !busy) begin
                    sigdecode_z_enable <= 1'b1;
                    busy               <= 1'b1;
                    done               <= 1'b0;
                end
            end
            if (access && pwrite && paddr == `APB_DEST_ADDR) begin
                dest_base_addr <= pwdata[MAW-1:0];
            end
        end
    end

    // ========================================
    // Memory requests from the APB side
    // ========================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rd_phase     <= '0;
            apb_sig_req  <= '{rd_wr_en: mldsa_mem_pkg::RW_IDLE, addr: '0};
            apb_poly_req <= '{rd_wr_en: mldsa_mem_pkg::RW_IDLE, addr: '0};
        end else begin
            apb_sig_req  <= '{rd_wr_en: mldsa_mem_pkg::RW_IDLE, addr: '0};
            apb_poly_req <= '{rd_wr_en: mldsa_mem_pkg::RW_IDLE, addr: '0};
            // Phase 0 issues the read, phase 1 waits for data, phase 2 completes
            if (access && poly_rd) begin
                rd_phase <= (rd_phase == 2'd2) ? 2'd0 : rd_phase + 2'd1;
                if (rd_phase == 2'd0) begin
                    apb_poly_req <= '{rd_wr_en: mldsa_mem_pkg::RW_READ,
                                      addr: poly_off[MAW+3:4]};
                end
            end else begin
                rd_phase <= '0;
            end
            if (sig_wr && lane == 2'd3) begin
                apb_sig_req <= '{rd_wr_en: mldsa_mem_pkg::RW_WRITE, addr: sig_off[MAW+3:4]};
            end
        end
    end

    // Lanes 0 to 2 are staged until lane 3 completes the word
    always_ff @(posedge clk) begin
        if (sig_wr) begin
            if (lane == 2'd3) begin
                apb_sig_wdata <= {pwdata[`MLDSA_GAMMA1_BITS:0], stage[2], stage[1], stage[0]};
            end else begin
                stage[lane] <= pwdata[`MLDSA_GAMMA1_BITS:0];
            end
        end
    end

    // Port a arbitration
    assign dec_sig_wide = '{rd_wr_en: dec_sig_req.rd_wr_en, addr: MAW'(dec_sig_req.addr)};
    assign sig_a_req    = busy ? dec_sig_wide : apb_sig_req;
    assign poly_a_req   = busy ? dec_mem_req : apb_poly_req;
    assign sig_a_wdata  = apb_sig_wdata;
    assign poly_a_wdata = dec_mem_wdata;

endmodule

// File: verilog/sigdecode_z_subsys.sv
// Z-decoder subsystem behind a single APB3 slave port
// The signature buffer holds 448 words, the polynomial memory 1024
`timescale 1ns/1ps
`include "mldsa_defines.svh"

module sigdecode_z_subsys (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic                             dec_enable;
    logic                             dec_zeroize;
    logic                             dec_done;
    logic [`MLDSA_MEM_ADDR_WIDTH-1:0] dest_base;
    mldsa_mem_pkg::sig_mem_if_t       sig_rd_req_a;
    mldsa_mem_pkg::sig_mem_if_t       sig_rd_req_b;
    mldsa_mem_pkg::mem_if_t           poly_wr_req_a;
    mldsa_mem_pkg::mem_if_t           poly_wr_req_b;
    mldsa_mem_pkg::mem_if_t           sig_a_req;
    mldsa_mem_pkg::mem_if_t           poly_a_req;
    mldsa_coeff_pkg::poly_word_t      poly_wr_data_a;
    mldsa_coeff_pkg::poly_word_t      poly_wr_data_b;
    mldsa_coeff_pkg::poly_word_t      poly_a_wdata;
    mldsa_coeff_pkg::poly_word_t      poly_a_rdata;
    mldsa_coeff_pkg::sig_word_t       sig_a_wdata;
    mldsa_coeff_pkg::sig_word_t       sig_a_rdata;
    mldsa_coeff_pkg::sig_word_t       sig_b_rdata;

    mldsa_apb_ctrl u_apb_ctrl (
        .clk                (clk),
        .reset_n            (reset_n),
        .psel               (psel),
        .penable            (penable),
        .pwrite             (pwrite),
        .paddr              (paddr),
        .pwdata             (pwdata),
        .prdata             (prdata),
        .pready             (pready),
        .pslverr            (pslverr),
        .sigdecode_z_enable (dec_enable),
        .zeroize            (dec_zeroize),
        .dest_base_addr     (dest_base),
        .sigdecode_z_done   (dec_done),
        .dec_sig_req        (sig_rd_req_a),
        .dec_mem_req        (poly_wr_req_a),
        .dec_mem_wdata      (poly_wr_data_a),
        .sig_a_req          (sig_a_req),
        .sig_a_wdata        (sig_a_wdata),
        .poly_a_req         (poly_a_req),
        .poly_a_wdata       (poly_a_wdata),
        .poly_a_rdata       (poly_a_rdata)
    );

    sigdecode_z_top u_decoder (
        .clk                (clk),
        .reset_n            (reset_n),
        .zeroize            (dec_zeroize),
        .sigdecode_z_enable (dec_enable),
        .dest_base_addr     (dest_base),
        .mem_a_wr_req       (poly_wr_req_a),
        .mem_b_wr_req       (poly_wr_req_b),
        .mem_a_wr_data      (poly_wr_data_a),
        .mem_b_wr_data      (poly_wr_data_b),
        .sigmem_a_rd_req    (sig_rd_req_a),
        .sigmem_b_rd_req    (sig_rd_req_b),
        .sigmem_a_rd_data   (sig_a_rdata),
        .sigmem_b_rd_data   (sig_b_rdata),
        .sigdecode_z_done   (dec_done)
    );

    // Port b of the buffer is read-only and driven by the decoder alone
    mldsa_dp_mem #(
        .word_t (mldsa_coeff_pkg::sig_word_t),
        .DEPTH  (`MLDSA_Z_WORDS)
    ) u_sig_mem (
        .clk     (clk),
        .a_req   (sig_a_req),
        .b_req   ({sig_rd_req_b.rd_wr_en, 1'b0, sig_rd_req_b.addr}),
        .a_wdata (sig_a_wdata),
        .b_wdata ('0),
        .a_rdata (sig_a_rdata),
        .b_rdata (sig_b_rdata)
    );

    mldsa_dp_mem #(
        .word_t (mldsa_coeff_pkg::poly_word_t),
        .DEPTH  (1 << `MLDSA_MEM_ADDR_WIDTH)
    ) u_poly_mem (
        .clk     (clk),
        .a_req   (poly_a_req),
        .b_req   (poly_wr_req_b),
        .a_wdata (poly_a_wdata),
        .b_wdata (poly_wr_data_b),
        .a_rdata (poly_a_rdata),
        .b_rdata ()
    );

endmodule

// File: sim/sigdecode_z_tb.sv
// Testbench of the z-decoder subsystem, driven only through APB
// Directed vectors come from sim/sigdecode_z_vectors.hex, run from the project root
// The first failing check stops the run
`timescale 1ns/1ps
`include "mldsa_defines.svh"

module sigdecode_z_tb;

    localparam int NCOEFF = `MLDSA_L * `MLDSA_N;
    localparam int NVEC = 34;
    localparam int MAX_WAITS = 8;
    localparam int MAX_POLLS = 200;
    localparam int unsigned GAMMA1 = 1 << `MLDSA_GAMMA1_BITS;
    // Four decoder runs with about two APB transfers per coefficient in each
    localparam int RUNS = 4;
    localparam int XFERS = 2 * NCOEFF + 16;
    localparam int TIMEOUT_NS = RUNS * (228 + 4 * XFERS) * 100 * 2;

    logic        clk;
    logic        reset_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int unsigned             seed_sink;
    logic [23:0]             vec_mem [0:3*NVEC-1];
    mldsa_coeff_pkg::enc_z_t z_buf [NCOEFF];
    mldsa_coeff_pkg::enc_z_t z_prev [NCOEFF];

    sigdecode_z_subsys dut0 (
        .clk     (clk),
        .reset_n (reset_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #50 clk = ~clk;

    // ========================================
    // Reference model and checks
    // ========================================
    function automatic mldsa_coeff_pkg::coeff_t decode_ref(input mldsa_coeff_pkg::enc_z_t x);
        int unsigned v;
        v = 32'(x);
        if (v <= GAMMA1) begin
            return mldsa_coeff_pkg::coeff_t'(GAMMA1 - v);
        end
        return mldsa_coeff_pkg::coeff_t'(`MLDSA_Q + GAMMA1 - v);
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_coeff(input string name, input int idx,
                               input mldsa_coeff_pkg::coeff_t exp,
                               input mldsa_coeff_pkg::coeff_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Error %s[%0d]: expected %h, actual %h",
                                        name, idx, exp, act));
        end
    endtask

    task automatic check_status(input string name, input logic [1:0] exp,
                                input logic [1:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Error %s: expected pslverr %b, actual %b",
                                        name, exp, act));
        end
    endtask

    task automatic check_waits(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_with_failure($sformatf("Error %s: expected %0d wait states, actual %0d",
                                        name, exp, act));
        end
    endtask

    // ========================================
    // APB access
    // ========================================
    // Inputs change on the falling edge and the response is sampled just after it
    task automatic apb_transfer(input logic wr, input logic [15:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err,
                                output int waits);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        #1;
        while (!pready) begin
            waits++;
            if (waits > MAX_WAITS) begin
                stop_with_failure($sformatf("APB transfer at %h never saw pready", addr));
            end
            @(negedge clk);
            #1;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
        logic [31:0] rd_sink;
        logic        err;
        int          waits;
        apb_transfer(1'b1, addr, data, rd_sink, err, waits);
        check_resp("apb_write", 1'b0, err);
        check_waits("apb_write", 0, waits);
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [31:0] data);
        logic err;
        int   waits;
        apb_transfer(1'b0, addr, 32'h0, data, err, waits);
        check_resp("apb_read", 1'b0, err);
        // Poly reads wait one cycle for the request and one for the read data
        check_waits("apb_read", (addr >= `APB_POLY_BASE) ? 2 : 0, waits);
    endtask

    function automatic logic [15:0] sig_addr(input int k);
        return 16'(`APB_SIG_BASE + 4 * k);
    endfunction

    function automatic logic [15:0] poly_addr(input int slot);
        return 16'(`APB_POLY_BASE + 4 * slot);
    endfunction

    // ========================================
    // Run steps
    // ========================================
    task automatic read_status(output logic [1:0] st);
        logic [31:0] d;
        apb_read(`APB_STATUS_ADDR, d);
        st = d[1:0];
    endtask

    task automatic fill_random();
        for (int k = 0; k < NCOEFF; k++) begin
            z_buf[k] = mldsa_coeff_pkg::enc_z_t'($urandom);
        end
    endtask

    task automatic write_buffer();
        for (int k = 0; k < NCOEFF; k++) begin
            apb_write(sig_addr(k), 32'(z_buf[k]));
        end
    endtask

    task automatic start_decoder(input int base);
        logic [1:0] st;
        apb_write(`APB_DEST_ADDR, 32'(base));
        apb_write(`APB_CTRL_ADDR, 32'h1);
        read_status(st);
        check_status("status_after_start", 2'b10, st);
    endtask

    task automatic wait_done();
        logic [1:0] st;
        int         polls;
        polls = 0;
        st    = 2'b00;
        while (!st[0]) begin
            polls++;
            if (polls > MAX_POLLS) begin
                stop_with_failure("Decoder never reported done in the STATUS register");
            end
            read_status(st);
        end
        check_status("status_after_done", 2'b01, st);
    endtask

    task automatic check_all(input string name, input int base);
        logic [31:0] d;
        for (int k = 0; k < NCOEFF; k++) begin
            apb_read(poly_addr(base * 4 + k), d);
            check_coeff(name, k, decode_ref(z_buf[k]), d[23:0]);
        end
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        stop_with_failure("Watchdog expired before the tests finished");
    end

    initial begin
        logic [1:0]  st;
        logic [31:0] d;
        logic        err;
        int          w;
        int          k;
        clk        = 1'b0;
        reset_n    = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        seed_sink  = $urandom(32'hc919_996d);
        $readmemh("sim/sigdecode_z_vectors.hex", vec_mem);
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        read_status(st);
        check_status("status_after_reset", 2'b00, st);

        // Directed corners over a random background are decoded at base 0
        fill_random();
        for (int v = 0; v < NVEC; v++) begin
            z_buf[int'(vec_mem[3*v])] = mldsa_coeff_pkg::enc_z_t'(vec_mem[3*v+1]);
        end
        write_buffer();
        start_decoder(0);
        wait_done();
        for (int v = 0; v < NVEC; v++) begin
            k = int'(vec_mem[3*v]);
            check_coeff("vector_rule", k,
                        decode_ref(mldsa_coeff_pkg::enc_z_t'(vec_mem[3*v+1])), vec_mem[3*v+2]);
            apb_read(poly_addr(k), d);
            check_coeff("directed", k, vec_mem[3*v+2], d[23:0]);
        end
        check_all("run0_decode", 0);
        read_status(st);
        check_status("status_holds_done", 2'b01, st);

        apb_transfer(1'b0, 16'h0100, 32'h0, d, err, w);
        check_resp("unmapped_read", 1'b1, err);

        // Second run lands at 0x200 and must leave the first run's words alone
        z_prev = z_buf;
        fill_random();
        write_buffer();
        read_status(st);
        check_status("status_before_start", 2'b01, st);
        start_decoder(32'h200);
        apb_transfer(1'b0, poly_addr(0), 32'h0, d, err, w);
        check_resp("poly_read_busy", 1'b1, err);
        wait_done();
        check_all("run1_decode", 32'h200);
        for (int i = 0; i < 64; i++) begin
            k = (i == 0) ? NCOEFF - 1 : int'($urandom % NCOEFF);
            apb_read(poly_addr(k), d);
            check_coeff("run0_kept", k, decode_ref(z_prev[k]), d[23:0]);
        end

        // Zeroize in mid-run and then a clean run over new data
        fill_random();
        write_buffer();
        start_decoder(0);
        apb_write(`APB_CTRL_ADDR, 32'h2);
        read_status(st);
        check_status("status_after_zeroize", 2'b00, st);
        repeat (300) @(negedge clk);
        read_status(st);
        check_status("status_zeroize_settled", 2'b00, st);
        // The aborted run never reached the last word, so it still holds the first run's value
        apb_read(poly_addr(NCOEFF - 1), d);
        check_coeff("zeroize_abort", NCOEFF - 1, decode_ref(z_prev[NCOEFF - 1]), d[23:0]);
        start_decoder(0);
        wait_done();
        check_all("run_after_zeroize", 0);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
verilog/mldsa_mem_pkg.sv
verilog/mldsa_coeff_pkg.sv
verilog/sigdecode_z_unit.sv
verilog/sigdecode_z_top.sv
verilog/mldsa_dp_mem.sv
verilog/mldsa_apb_ctrl.sv
verilog/sigdecode_z_subsys.sv
sim/sigdecode_z_tb.sv

// File: Makefile
# Verilator build and run of the z-decoder testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = sigdecode_z_tb
FILELIST  = files.f
OBJDIR    = obj_dir

SIM  = $(OBJDIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The run passes only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJDIR)

// File: sim/sigdecode_z_vectors.hex
// Columns: coefficient index, encoded z value, expected decoded coefficient
// Expected value is 2^19 - z for z <= 2^19, otherwise q + 2^19 - z
0000 00000 080000
0001 00001 07FFFF
0002 7FFFF 000001
0003 80000 000000
0004 80001 7FE000
0005 FFFFF 77E002
0006 00002 07FFFE
0007 7FFFE 000002
0008 80002 7FDFFF
0009 FFFFE 77E003
0050 08000 078000
0051 88000 7F6001
00FF 40000 040000
0100 C0000 7BE001
01FF 10000 070000
0200 F0000 78E001
02AA 00010 07FFF0
02AB 80010 7FDFF1
0300 7FFF0 000010
0301 8FFFF 7EE002
0400 20000 060000
0401 A0000 7DE001
0402 60000 020000
0403 E0000 79E001
0500 00100 07FF00
0501 80100 7FDF01
0555 55555 02AAAB
0556 D5555 7A8AAC
0600 3FFFF 040001
0601 BFFFF 7BE002
06FC 00003 07FFFD
06FD 80003 7FDFFE
06FE 7FFFD 000003
06FF FFFFF 77E002
